/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module tb_axi_mem -f files.f
	@out="$$(./obj_dir/Vtb_axi_mem)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* axi_mem_pkg.sv */
package axi_mem_pkg;

  // Kind of transaction held by the bridge.
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } axi_op_t;

  // Request acceptance states.
  typedef enum logic [1:0] {
    REQ_IDLE  = 2'd0, // Waiting for AR or AW.
    REQ_WDATA = 2'd1, // Address taken, waiting for the W beat.
    REQ_BUSY  = 2'd2  // Transaction in flight until release.
  } req_state_t;

  // Memory access sequencer states.
  typedef enum logic [1:0] {
    SEQ_IDLE = 2'd0,
    SEQ_LOW  = 2'd1, // Word at the doubleword address.
    SEQ_HIGH = 2'd2, // Word at the doubleword address plus 4.
    SEQ_DONE = 2'd3
  } seq_state_t;

  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

/* axi_mem_top.sv */
`timescale 1ns/100ps

module axi_mem_top #(
  parameter int ADDR_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int MEM_WORDS  = 1024
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  logic [ADDR_WIDTH-1:0] ar_addr_i,
  input  logic [ID_WIDTH-1:0]   ar_id_i,

  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  logic [ADDR_WIDTH-1:0] aw_addr_i,
  input  logic [ID_WIDTH-1:0]   aw_id_i,

  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  input  logic [63:0]           w_data_i,
  input  logic [7:0]            w_strb_i,

  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output logic [63:0]           r_data_o,
  output logic [ID_WIDTH-1:0]   r_id_o,
  output logic [1:0]            r_resp_o,
  output logic                  r_last_o,

  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output logic [ID_WIDTH-1:0]   b_id_o,
  output logic [1:0]            b_resp_o
);

  localparam int RAM_AW = $clog2(MEM_WORDS) + 2; // Byte address bits seen by the memory.

  logic                  start;
  axi_mem_pkg::axi_op_t  op;
  logic [ADDR_WIDTH-1:0] addr;
  logic [63:0]           wdata;
  logic [7:0]            wstrb;
  logic [ID_WIDTH-1:0]   id;
  logic                  resp_release;

  logic                  mem_req;
  logic                  mem_we;
  logic [ADDR_WIDTH-1:0] mem_addr;
  logic [3:0]            mem_be;
  logic [31:0]           mem_wdata;
  logic [31:0]           mem_rdata;

  logic                  done;
  logic [63:0]           rdata;

  axi_req_accept #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .ID_WIDTH   (ID_WIDTH)
  ) u_req (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid_i),
    .ar_addr_i  (ar_addr_i),
    .ar_id_i    (ar_id_i),
    .ar_ready_o (ar_ready_o),
    .aw_valid_i (aw_valid_i),
    .aw_addr_i  (aw_addr_i),
    .aw_id_i    (aw_id_i),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_ready_o  (w_ready_o),
    .release_i  (resp_release),
    .start_o    (start),
    .op_o       (op),
    .addr_o     (addr),
    .wdata_o    (wdata),
    .wstrb_o    (wstrb),
    .id_o       (id)
  );

  mem_access_seq #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start),
    .op_i        (op),
    .addr_i      (addr),
    .wdata_i     (wdata),
    .wstrb_i     (wstrb),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_be_o    (mem_be),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata),
    .done_o      (done),
    .rdata_o     (rdata)
  );

  axi_resp_hold #(
    .ID_WIDTH (ID_WIDTH)
  ) u_resp (
    .clk       (clk),
    .rst_n     (rst_n),
    .done_i    (done),
    .op_i      (op),
    .id_i      (id),
    .rdata_i   (rdata),
    .r_valid_o (r_valid_o),
    .r_data_o  (r_data_o),
    .r_id_o    (r_id_o),
    .r_resp_o  (r_resp_o),
    .r_last_o  (r_last_o),
    .r_ready_i (r_ready_i),
    .b_valid_o (b_valid_o),
    .b_id_o    (b_id_o),
    .b_resp_o  (b_resp_o),
    .b_ready_i (b_ready_i),
    .release_o (resp_release)
  );

  word_ram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_ram (
    .clk     (clk),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr[RAM_AW-1:0]),
    .be_i    (mem_be),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

/* axi_req_accept.sv */
`timescale 1ns/100ps

module axi_req_accept #(
  parameter int ADDR_WIDTH = 32,
  parameter int ID_WIDTH   = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  ar_valid_i,
  input  logic [ADDR_WIDTH-1:0] ar_addr_i,
  input  logic [ID_WIDTH-1:0]   ar_id_i,
  output logic                  ar_ready_o,

  input  logic                  aw_valid_i,
  input  logic [ADDR_WIDTH-1:0] aw_addr_i,
  input  logic [ID_WIDTH-1:0]   aw_id_i,
  output logic                  aw_ready_o,

  input  logic                  w_valid_i,
  input  logic [63:0]           w_data_i,
  input  logic [7:0]            w_strb_i,
  output logic                  w_ready_o,

  input  logic                  release_i,

  output logic                  start_o,
  output axi_mem_pkg::axi_op_t  op_o,
  output logic [ADDR_WIDTH-1:0] addr_o,
  output logic [63:0]           wdata_o,
  output logic [7:0]            wstrb_o,
  output logic [ID_WIDTH-1:0]   id_o
);

  axi_mem_pkg::req_state_t state_q;
  axi_mem_pkg::req_state_t state_d;
  logic                    ar_hs;
  logic                    aw_hs;
  logic                    w_hs;

  // Read wins when both address channels are valid.
  assign ar_ready_o = (state_q == axi_mem_pkg::REQ_IDLE) && ar_valid_i;
  assign aw_ready_o = (state_q == axi_mem_pkg::REQ_IDLE) && aw_valid_i && !ar_valid_i;
  assign w_ready_o  = (state_q == axi_mem_pkg::REQ_WDATA);

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      axi_mem_pkg::REQ_IDLE:
      begin
        if (ar_hs)
          state_d = axi_mem_pkg::REQ_BUSY;
        else if (aw_hs)
          state_d = axi_mem_pkg::REQ_WDATA;
      end
      axi_mem_pkg::REQ_WDATA:
      begin
        if (w_hs)
          state_d = axi_mem_pkg::REQ_BUSY;
      end
      axi_mem_pkg::REQ_BUSY:
      begin
        if (release_i)
          state_d = axi_mem_pkg::REQ_IDLE; // Response accepted.
      end
      default:
        state_d = axi_mem_pkg::REQ_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= axi_mem_pkg::REQ_IDLE;
      start_o <= 1'b0;
      op_o    <= axi_mem_pkg::OP_READ;
    end
    else
    begin
      state_q <= state_d;
      start_o <= (state_d == axi_mem_pkg::REQ_BUSY) && (state_q != axi_mem_pkg::REQ_BUSY);
      if (ar_hs)
        op_o <= axi_mem_pkg::OP_READ;
      else if (aw_hs)
        op_o <= axi_mem_pkg::OP_WRITE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ar_hs)
    begin
      addr_o <= ar_addr_i;
      id_o   <= ar_id_i;
    end
    else if (aw_hs)
    begin
      addr_o <= aw_addr_i;
      id_o   <= aw_id_i;
    end
    if (w_hs)
    begin
      wdata_o <= w_data_i;
      wstrb_o <= w_strb_i;
    end
  end

  a_release_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
    release_i |-> (state_q == axi_mem_pkg::REQ_BUSY));

endmodule

/* axi_resp_hold.sv */
`timescale 1ns/100ps

module axi_resp_hold #(
  parameter int ID_WIDTH = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 done_i,
  input  axi_mem_pkg::axi_op_t op_i,
  input  logic [ID_WIDTH-1:0]  id_i,
  input  logic [63:0]          rdata_i,

  output logic                 r_valid_o,
  output logic [63:0]          r_data_o,
  output logic [ID_WIDTH-1:0]  r_id_o,
  output logic [1:0]           r_resp_o,
  output logic                 r_last_o,
  input  logic                 r_ready_i,

  output logic                 b_valid_o,
  output logic [ID_WIDTH-1:0]  b_id_o,
  output logic [1:0]           b_resp_o,
  input  logic                 b_ready_i,

  output logic                 release_o
);

  logic                r_hs;
  logic                b_hs;
  logic [ID_WIDTH-1:0] id_q;

  assign r_hs = r_valid_o && r_ready_i;
  assign b_hs = b_valid_o && b_ready_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      r_valid_o <= 1'b0;
      b_valid_o <= 1'b0;
    end
    else if (done_i)
    begin
      r_valid_o <= (op_i == axi_mem_pkg::OP_READ);
      b_valid_o <= (op_i == axi_mem_pkg::OP_WRITE);
    end
    else
    begin
      if (r_hs)
        r_valid_o <= 1'b0;
      if (b_hs)
        b_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (done_i)
      id_q <= id_i;
  end

  assign r_data_o  = rdata_i; // Held by the sequencer until the next start.
  assign r_id_o    = id_q;
  assign r_resp_o  = axi_mem_pkg::RESP_OKAY;
  assign r_last_o  = 1'b1; // Single beat only.
  assign b_id_o    = id_q;
  assign b_resp_o  = axi_mem_pkg::RESP_OKAY;
  assign release_o = r_hs || b_hs;

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_id_o));

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o));

endmodule

/* files.f */
axi_mem_pkg.sv
word_ram.sv
axi_req_accept.sv
mem_access_seq.sv
axi_resp_hold.sv
axi_mem_top.sv
tb_axi_mem.sv

/* mem_access_seq.sv */
`timescale 1ns/100ps

module mem_access_seq #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  start_i,
  input  axi_mem_pkg::axi_op_t  op_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [63:0]           wdata_i,
  input  logic [7:0]            wstrb_i,

  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [ADDR_WIDTH-1:0] mem_addr_o,
  output logic [3:0]            mem_be_o,
  output logic [31:0]           mem_wdata_o,
  input  logic [31:0]           mem_rdata_i,

  output logic                  done_o,
  output logic [63:0]           rdata_o
);

  axi_mem_pkg::seq_state_t state_q;
  axi_mem_pkg::seq_state_t state_d;
  logic                    is_read;

  assign is_read = (op_i == axi_mem_pkg::OP_READ);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      axi_mem_pkg::SEQ_IDLE:
      begin
        if (start_i)
          state_d = axi_mem_pkg::SEQ_LOW;
      end
      axi_mem_pkg::SEQ_LOW:
        state_d = axi_mem_pkg::SEQ_HIGH;
      axi_mem_pkg::SEQ_HIGH:
        state_d = axi_mem_pkg::SEQ_DONE;
      axi_mem_pkg::SEQ_DONE:
        state_d = axi_mem_pkg::SEQ_IDLE;
      default:
        state_d = axi_mem_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= axi_mem_pkg::SEQ_IDLE;
    else
      state_q <= state_d;
  end

  // Bits 2:0 of the request address are dropped.
  always_comb
  begin
    mem_req_o   = 1'b0;
    mem_addr_o  = {addr_i[ADDR_WIDTH-1:3], 3'b000};
    mem_be_o    = wstrb_i[3:0];
    mem_wdata_o = wdata_i[31:0];
    case (state_q)
      axi_mem_pkg::SEQ_LOW:
      begin
        mem_req_o = 1'b1;
      end
      axi_mem_pkg::SEQ_HIGH:
      begin
        mem_req_o   = 1'b1;
        mem_addr_o  = {addr_i[ADDR_WIDTH-1:3], 3'b100};
        mem_be_o    = wstrb_i[7:4];
        mem_wdata_o = wdata_i[63:32];
      end
      default:
      begin
        mem_req_o = 1'b0;
      end
    endcase
  end

  assign mem_we_o = mem_req_o && !is_read;
  assign done_o   = (state_q == axi_mem_pkg::SEQ_DONE);

  // Memory returns each word one cycle after its request.
  always_ff @(posedge clk)
  begin
    if (is_read && (state_q == axi_mem_pkg::SEQ_HIGH))
      rdata_o[31:0] <= mem_rdata_i; // Low word.
    if (is_read && (state_q == axi_mem_pkg::SEQ_DONE))
      rdata_o[63:32] <= mem_rdata_i; // High word.
  end

  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> (state_q == axi_mem_pkg::SEQ_IDLE));

endmodule

/* tb_axi_mem.sv */
`timescale 1ns/100ps

module tb_axi_mem;

  localparam int N_ROWS         = 14;
  localparam int TIMEOUT_CYCLES = 40 * N_ROWS + 100;

  localparam axi_mem_pkg::axi_op_t RD = axi_mem_pkg::OP_READ;
  localparam axi_mem_pkg::axi_op_t WR = axi_mem_pkg::OP_WRITE;

  typedef struct packed {
    axi_mem_pkg::axi_op_t op;
    logic [31:0]          addr;
    logic [3:0]           id;
    logic [63:0]          wdata;
    logic [7:0]           strb;
    logic                 aw_with_ar; // Write to the same address offered with the read.
    logic [63:0]          exp_data;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        ar_valid;
  logic        ar_ready;
  logic [31:0] ar_addr;
  logic [3:0]  ar_id;
  logic        aw_valid;
  logic        aw_ready;
  logic [31:0] aw_addr;
  logic [3:0]  aw_id;
  logic        w_valid;
  logic        w_ready;
  logic [63:0] w_data;
  logic [7:0]  w_strb;
  logic        r_valid;
  logic        r_ready;
  logic [63:0] r_data;
  logic [3:0]  r_id;
  logic [1:0]  r_resp;
  logic        r_last;
  logic        b_valid;
  logic        b_ready;
  logic [3:0]  b_id;
  logic [1:0]  b_resp;

  row_t   rows [N_ROWS];
  int     cyc = 0;
  integer seed = 32'hd9d0_7291;

  axi_mem_top #(
    .ADDR_WIDTH (32),
    .ID_WIDTH   (4),
    .MEM_WORDS  (1024)
  ) u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_addr_i  (ar_addr),
    .ar_id_i    (ar_id),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .aw_addr_i  (aw_addr),
    .aw_id_i    (aw_id),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .w_data_i   (w_data),
    .w_strb_i   (w_strb),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_data_o   (r_data),
    .r_id_o     (r_id),
    .r_resp_o   (r_resp),
    .r_last_o   (r_last),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready),
    .b_id_o     (b_id),
    .b_resp_o   (b_resp)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $fatal(1);
    end
  end

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // Memory holds 1024 words, so byte addresses wrap at 32'h1000.
  task automatic load_table();
    rows[0]  = '{WR, 32'h0010, 4'd3, 64'h1122_3344_5566_7788, 8'hff, 1'b0, 64'd0};
    rows[1]  = '{RD, 32'h0010, 4'd5, 64'd0, 8'h00, 1'b0, 64'h1122_3344_5566_7788};
    rows[2]  = '{WR, 32'h0020, 4'd1, 64'hA0A1_A2A3_A4A5_A6A7, 8'hff, 1'b0, 64'd0};
    rows[3]  = '{WR, 32'h0020, 4'd2, 64'hFFFF_FFFF_FFFF_FFFF, 8'h05, 1'b0, 64'd0};
    rows[4]  = '{WR, 32'h0020, 4'd4, 64'h5B5B_5B5B_5B5B_5B5B, 8'h90, 1'b0, 64'd0};
    rows[5]  = '{RD, 32'h0025, 4'd6, 64'd0, 8'h00, 1'b0, 64'h5BA1_A25B_A4FF_A6FF};
    rows[6]  = '{RD, 32'h0020, 4'd7, 64'd0, 8'h00, 1'b0, 64'h5BA1_A25B_A4FF_A6FF};
    rows[7]  = '{RD, 32'h0010, 4'd8, 64'hDEAD_BEEF_0BAD_F00D, 8'hf0, 1'b1,
                 64'h1122_3344_5566_7788}; // Read sees memory before the write.
    rows[8]  = '{RD, 32'h0010, 4'd10, 64'd0, 8'h00, 1'b0, 64'hDEAD_BEEF_5566_7788};
    rows[9]  = '{WR, 32'h1030, 4'd11, 64'h0123_4567_89AB_CDEF, 8'hff, 1'b0, 64'd0};
    rows[10] = '{RD, 32'h0030, 4'd12, 64'd0, 8'h00, 1'b0, 64'h0123_4567_89AB_CDEF};
    rows[11] = '{WR, 32'h0038, 4'd13, 64'hCAFE_F00D_1234_5678, 8'hff, 1'b0, 64'd0};
    rows[12] = '{RD, 32'h2038, 4'd14, 64'd0, 8'h00, 1'b0, 64'hCAFE_F00D_1234_5678};
    rows[13] = '{RD, 32'h1010, 4'd0, 64'd0, 8'h00, 1'b0, 64'hDEAD_BEEF_5566_7788};
  endtask

  task automatic wait_ar(output int hs_cyc);
    @(negedge clk);
    while (!ar_ready)
    begin
      @(negedge clk);
    end
    compare("aw_ready_o", 64'(aw_ready), 64'd0); // Read has priority.
    hs_cyc = cyc;
    @(posedge clk);
    #2;
    ar_valid = 1'b0;
  endtask

  task automatic wait_aw_w(input logic [63:0] data, input logic [7:0] strb, output int hs_cyc);
    int aw_cyc;
    @(negedge clk);
    while (!aw_ready)
    begin
      @(negedge clk);
    end
    aw_cyc = cyc;
    @(posedge clk);
    #2;
    aw_valid = 1'b0;
    w_valid  = 1'b1;
    w_data   = data;
    w_strb   = strb;
    @(negedge clk);
    while (!w_ready)
    begin
      @(negedge clk);
    end
    hs_cyc = cyc;
    compare("w handshake cycle", 64'(hs_cyc), 64'(aw_cyc + 1));
    @(posedge clk);
    #2;
    w_valid = 1'b0;
  endtask

  task automatic check_response(input logic is_read, input int hs_cyc, input logic [3:0] id,
                                input logic [63:0] exp_data);
    int   delay;
    int   k;
    logic ar_valid_save;
    logic aw_valid_save;
    ar_valid_save = ar_valid;
    aw_valid_save = aw_valid;
    // Offer another address; the bridge must not take it before release.
    if (is_read)
      aw_valid = 1'b1;
    else
      ar_valid = 1'b1;
    delay = $unsigned($random(seed)) % 4;
    if (delay == 0)
    begin
      r_ready = is_read;
      b_ready = !is_read;
    end
    @(negedge clk);
    while (!(is_read ? r_valid : b_valid))
    begin
      compare("ar_ready_o", 64'(ar_ready), 64'd0);
      compare("aw_ready_o", 64'(aw_ready), 64'd0);
      @(negedge clk);
    end
    compare("response cycle", 64'(cyc), 64'(hs_cyc + 5));
    for (k = 0; k <= delay; k++)
    begin
      if (k > 0)
      begin
        @(posedge clk);
        #2;
        r_ready = is_read && (k == delay);
        b_ready = !is_read && (k == delay);
        @(negedge clk);
      end
      if (is_read)
      begin
        compare("r_valid_o", 64'(r_valid), 64'd1);
        compare("r_data_o", r_data, exp_data);
        compare("r_id_o", 64'(r_id), 64'(id));
        compare("r_resp_o", 64'(r_resp), 64'(axi_mem_pkg::RESP_OKAY));
        compare("r_last_o", 64'(r_last), 64'd1);
        compare("b_valid_o", 64'(b_valid), 64'd0);
      end
      else
      begin
        compare("b_valid_o", 64'(b_valid), 64'd1);
        compare("b_id_o", 64'(b_id), 64'(id));
        compare("b_resp_o", 64'(b_resp), 64'(axi_mem_pkg::RESP_OKAY));
        compare("r_valid_o", 64'(r_valid), 64'd0);
      end
      compare("ar_ready_o", 64'(ar_ready), 64'd0);
      compare("aw_ready_o", 64'(aw_ready), 64'd0);
    end
    @(posedge clk);
    #2;
    r_ready  = 1'b0;
    b_ready  = 1'b0;
    ar_valid = ar_valid_save;
    aw_valid = aw_valid_save;
    compare("r_valid_o", 64'(r_valid), 64'd0); // Dropped after the handshake.
    compare("b_valid_o", 64'(b_valid), 64'd0);
  endtask

  task automatic run_row(input row_t row);
    int hs;
    if (row.op == RD)
    begin
      ar_valid = 1'b1;
      ar_addr  = row.addr;
      ar_id    = row.id;
      if (row.aw_with_ar)
      begin
        aw_valid = 1'b1;
        aw_addr  = row.addr;
        aw_id    = row.id + 4'd1;
      end
      wait_ar(hs);
      check_response(1'b1, hs, row.id, row.exp_data);
      if (row.aw_with_ar)
      begin
        wait_aw_w(row.wdata, row.strb, hs);
        check_response(1'b0, hs, row.id + 4'd1, 64'd0);
      end
    end
    else
    begin
      aw_valid = 1'b1;
      aw_addr  = row.addr;
      aw_id    = row.id;
      wait_aw_w(row.wdata, row.strb, hs);
      check_response(1'b0, hs, row.id, 64'd0);
    end
  endtask

  initial
  begin
    rst_n    = 1'b0;
    ar_valid = 1'b0;
    ar_addr  = '0;
    ar_id    = '0;
    aw_valid = 1'b0;
    aw_addr  = '0;
    aw_id    = '0;
    w_valid  = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    r_ready  = 1'b0;
    b_ready  = 1'b0;
    load_table();
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    compare("ar_ready_o", 64'(ar_ready), 64'd0);
    compare("aw_ready_o", 64'(aw_ready), 64'd0);
    compare("w_ready_o", 64'(w_ready), 64'd0);
    compare("r_valid_o", 64'(r_valid), 64'd0);
    compare("b_valid_o", 64'(b_valid), 64'd0);
    @(posedge clk);
    #2;
    for (int i = 0; i < N_ROWS; i++)
    begin
      run_row(rows[i]);
    end
    $display("Test OK");
    $finish;
  end

endmodule

/* word_ram.sv */
`timescale 1ns/100ps

module word_ram #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                         clk,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(MEM_WORDS)+1:0] addr_i,
  input  logic [3:0]                   be_i,
  input  logic [31:0]                  wdata_i,
  output logic [31:0]                  rdata_o
);

  logic [31:0]                  mem [MEM_WORDS];
  logic [$clog2(MEM_WORDS)-1:0] idx;

  // Byte address in, word index out; upper bits wrap.
  assign idx = addr_i[$clog2(MEM_WORDS)+1:2];

  always_ff @(posedge clk)
  begin
    if (req_i && we_i)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (be_i[b])
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_i && !we_i)
      rdata_o <= mem[idx]; // One cycle read latency.
  end

endmodule
